// File: sim.f
+incdir+hw
hw/c2a_pkg.sv
hw/c2a_req_arbiter.sv
hw/c2a_tag_fifo.sv
hw/c2a_word_gather.sv
hw/c2a_write_tx.sv
hw/c2a_write_top.sv
tests/tb_c2a_write.sv

// File: tests/tb_c2a_write.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module tb_c2a_write;

  localparam int NC = `C2A_NUM_CACHE;
  localparam int NBLK = 8;
  localparam int BW = `C2A_BLOCK_WORDS;
  localparam int WPB = `C2A_WORDS_PER_BEAT;
  localparam int CLK_PERIOD = 8;

  logic clk_i;
  logic rst_i;
  logic [NC-1:0] req_v_i;
  logic [NC-1:0][`C2A_ADDR_W-1:0] req_addr_i;
  logic [NC-1:0] req_yumi_o;
  logic [NC-1:0][`C2A_WORD_W-1:0] dma_data_i;
  logic [NC-1:0] dma_v_i;
  logic [NC-1:0] dma_yumi_o;
  c2a_pkg::axi_aw_s aw_o;
  logic awvalid_o;
  logic awready_i;
  c2a_pkg::axi_w_s w_o;
  logic wvalid_o;
  logic wready_i;
  c2a_pkg::axi_b_s b_i;
  logic bvalid_i;
  logic bready_o;
  logic err_o;

  // blocks each cache writes back, in order
  logic [`C2A_ADDR_W-1:0] blk_addr [NC][NBLK];
  logic [`C2A_WORD_W-1:0] blk_word [NC][NBLK][BW];

  integer seed;
  int errors;
  int checks;
  int tests;
  logic run;
  logic full_rate;
  int req_lim;
  int req_idx [NC];
  int dma_pos [NC];
  logic [NC-1:0] pend_req;
  logic [NC-1:0] pend_dma;
  int b_pend;
  c2a_pkg::axi_resp_e b_resp;
  // arbiter model and burst order
  logic scanning;
  int last_win;
  int pred;
  int aw_q [$];
  int beat;
  int done_blk;

  c2a_write_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_aw(input c2a_pkg::axi_aw_s got, input c2a_pkg::axi_aw_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0t aw_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_w(input c2a_pkg::axi_w_s got, input c2a_pkg::axi_w_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0t w_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_yumi(input logic [NC-1:0] got, input logic [NC-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0t req_yumi_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0t err_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int base);
    tests++;
    $display("test %0d, %s: %s", tests, name, (errors == base) ? "pass" : "fail");
  endtask

  // caches and axi slave, all driven on the falling edge
  always @(negedge clk_i) begin : drive
    int c;
    int w;
    if (run) begin
      for (c = 0; c < NC; c++) begin
        if (!pend_req[c]) begin
          req_v_i[c] = 1'b0;
          if (req_idx[c] < req_lim && (full_rate || ($random(seed) & 1))) begin
            req_addr_i[c] = blk_addr[c][req_idx[c]];
            req_v_i[c] = 1'b1;
            pend_req[c] = 1'b1;
          end
        end
        w = dma_pos[c];
        // words only for blocks whose request was taken
        if (!pend_dma[c]) begin
          dma_v_i[c] = 1'b0;
          if (w / BW < req_idx[c] && (full_rate || ($random(seed) & 3) != 0)) begin
            dma_data_i[c] = blk_word[c][w / BW][w % BW];
            dma_v_i[c] = 1'b1;
            pend_dma[c] = 1'b1;
          end
        end
      end
      awready_i = full_rate || ($random(seed) & 1);
      wready_i = full_rate || (($random(seed) & 3) != 0);
      bvalid_i = (b_pend > 0) && (full_rate || ($random(seed) & 1));
      b_i.id = '0;
      b_i.resp = b_resp;
    end
  end

  always @(posedge clk_i) begin : monitor
    int c;
    int i;
    int blk;
    c2a_pkg::axi_aw_s exp_aw;
    c2a_pkg::axi_w_s exp_w;
    if (run) begin
      for (c = 0; c < NC; c++) begin
        if (dma_yumi_o[c]) begin
          if (!dma_v_i[c]) begin
            errors++;
            $display("word taken from cache %0d while its dma valid was low", c);
          end
          pend_dma[c] = 1'b0;
          dma_pos[c]++;
        end
      end
      checks++;
      if (bready_o !== 1'b1) begin
        errors++;
        $display("Error %0t bready_o got %b expected 1", $time, bready_o);
      end
      if (awvalid_o && awready_i) begin
        if (scanning) begin
          errors++;
          $display("burst address sent before any request could have been picked");
        end else begin
          exp_aw.id = '0;
          exp_aw.addr = blk_addr[pred][req_idx[pred]];
          exp_aw.len = 8'd3;
          exp_aw.size = 3'd3;
          exp_aw.burst = c2a_pkg::BURST_INCR;
          check_aw(aw_o, exp_aw);
          check_yumi(req_yumi_o, NC'(1) << pred);
          aw_q.push_back(pred * NBLK + req_idx[pred]);
          pend_req[pred] = 1'b0;
          req_idx[pred]++;
          last_win = pred;
          scanning = 1'b1;
        end
      end else begin
        check_yumi(req_yumi_o, '0);
        if (scanning) begin
          // first requester after the previous winner
          for (i = 1; i <= NC && scanning; i++) begin
            c = (last_win + i) % NC;
            if (req_v_i[c]) begin
              pred = c;
              scanning = 1'b0;
            end
          end
        end
      end
      if (wvalid_o && wready_i) begin
        if (aw_q.size() == 0) begin
          errors++;
          $display("write beat accepted with no burst outstanding");
        end else begin
          blk = aw_q[0];
          c = blk / NBLK;
          for (i = 0; i < WPB; i++) begin
            exp_w.data[i*`C2A_WORD_W +: `C2A_WORD_W] = blk_word[c][blk % NBLK][beat*WPB + i];
          end
          exp_w.strb = '1;
          exp_w.last = (beat == `C2A_BURST_LEN - 1);
          check_w(w_o, exp_w);
          if (exp_w.last) begin
            beat = 0;
            void'(aw_q.pop_front());
            done_blk++;
            b_pend++;
          end else begin
            beat++;
          end
        end
      end
      if (bvalid_i && bready_o && b_pend > 0) begin
        b_pend--;
      end
    end
  end

  initial begin
    #(NC * NBLK * 200 * CLK_PERIOD);
    $display("watchdog timeout with %0d of %0d blocks complete", done_blk, NC * NBLK);
    $display("tests failed");
    $finish;
  end

  initial begin
    int base;
    seed = 32'h3f67_605a;
    errors = 0;
    checks = 0;
    tests = 0;
    run = 1'b0;
    rst_i = 1'b1;
    req_v_i = '0;
    req_addr_i = '0;
    dma_data_i = '0;
    dma_v_i = '0;
    awready_i = 1'b0;
    wready_i = 1'b0;
    b_i = '0;
    bvalid_i = 1'b0;
    full_rate = 1'b1;
    req_lim = 0;
    pend_req = '0;
    pend_dma = '0;
    b_pend = 0;
    b_resp = c2a_pkg::RESP_OKAY;
    scanning = 1'b1;
    last_win = NC - 1;
    pred = 0;
    beat = 0;
    done_blk = 0;
    for (int c = 0; c < NC; c++) begin
      req_idx[c] = 0;
      dma_pos[c] = 0;
      for (int b = 0; b < NBLK; b++) begin
        // block aligned addresses
        blk_addr[c][b] = $random(seed) & ~32'h1f;
        for (int w = 0; w < BW; w++) begin
          blk_word[c][b][w] = $random(seed);
        end
      end
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #1 run = 1'b1;

    // two blocks per cache, everyone asks at once
    base = errors;
    req_lim = 2;
    while (done_blk < NC * 2) @(posedge clk_i);
    report_test("round robin with all caches requesting", base);

    base = errors;
    full_rate = 1'b0;
    req_lim = NBLK;
    while (done_blk < NC * NBLK || b_pend != 0) @(posedge clk_i);
    report_test("random back-pressure and dma gaps", base);

    base = errors;
    @(negedge clk_i);
    check_err(err_o, 1'b0);
    report_test("err_o low after okay responses", base);

    base = errors;
    #1;
    b_resp = c2a_pkg::RESP_SLVERR;
    b_pend = 1;
    while (b_pend != 0) @(posedge clk_i);
    repeat (2) @(negedge clk_i);
    check_err(err_o, 1'b1);
    repeat (10) @(negedge clk_i);
    check_err(err_o, 1'b1);
    report_test("err_o sticky after slverr", base);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: hw/c2a_write_top.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module c2a_write_top (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  // cache write-back requests
  input  logic [`C2A_NUM_CACHE-1:0]                   req_v_i,
  input  logic [`C2A_NUM_CACHE-1:0][`C2A_ADDR_W-1:0]  req_addr_i,
  output logic [`C2A_NUM_CACHE-1:0]                   req_yumi_o,
  // cache dma words
  input  logic [`C2A_NUM_CACHE-1:0][`C2A_WORD_W-1:0]  dma_data_i,
  input  logic [`C2A_NUM_CACHE-1:0]                   dma_v_i,
  output logic [`C2A_NUM_CACHE-1:0]                   dma_yumi_o,
  // axi memory port
  output c2a_pkg::axi_aw_s                            aw_o,
  output logic                                        awvalid_o,
  input  logic                                        awready_i,
  output c2a_pkg::axi_w_s                             w_o,
  output logic                                        wvalid_o,
  input  logic                                        wready_i,
  input  c2a_pkg::axi_b_s                             b_i,
  input  logic                                        bvalid_i,
  output logic                                        bready_o,
  output logic                                        err_o
);

  c2a_pkg::wb_req_s offer;
  logic offer_v;
  logic offer_yumi;

  c2a_req_arbiter i_arbiter (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_v_i(req_v_i),
    .req_addr_i(req_addr_i),
    .req_yumi_o(req_yumi_o),
    .offer_o(offer),
    .offer_v_o(offer_v),
    .offer_yumi_i(offer_yumi)
  );

  c2a_write_tx i_write_tx (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .offer_i(offer),
    .offer_v_i(offer_v),
    .offer_yumi_o(offer_yumi),
    .dma_data_i(dma_data_i),
    .dma_v_i(dma_v_i),
    .dma_yumi_o(dma_yumi_o),
    .aw_o(aw_o),
    .awvalid_o(awvalid_o),
    .awready_i(awready_i),
    .w_o(w_o),
    .wvalid_o(wvalid_o),
    .wready_i(wready_i),
    .b_i(b_i),
    .bvalid_i(bvalid_i),
    .bready_o(bready_o),
    .err_o(err_o)
  );

endmodule

// File: hw/c2a_write_tx.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module c2a_write_tx (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  // picked write-back request
  input  c2a_pkg::wb_req_s                            offer_i,
  input  logic                                        offer_v_i,
  output logic                                        offer_yumi_o,
  // cache dma words
  input  logic [`C2A_NUM_CACHE-1:0][`C2A_WORD_W-1:0]  dma_data_i,
  input  logic [`C2A_NUM_CACHE-1:0]                   dma_v_i,
  output logic [`C2A_NUM_CACHE-1:0]                   dma_yumi_o,
  // axi write channels
  output c2a_pkg::axi_aw_s                            aw_o,
  output logic                                        awvalid_o,
  input  logic                                        awready_i,
  output c2a_pkg::axi_w_s                             w_o,
  output logic                                        wvalid_o,
  input  logic                                        wready_i,
  input  c2a_pkg::axi_b_s                             b_i,
  input  logic                                        bvalid_i,
  output logic                                        bready_o,
  output logic                                        err_o
);

  localparam int NUM_CACHE = `C2A_NUM_CACHE;
  localparam int WORD_CNT_W = $clog2(`C2A_BLOCK_WORDS);
  localparam int BEAT_CNT_W = $clog2(`C2A_BURST_LEN);

  logic fifo_ready;
  logic fifo_push;
  logic fifo_v;
  logic fifo_yumi;
  logic [`C2A_TAG_W-1:0] head_tag;

  logic gather_v;
  logic gather_ready;
  logic beat_v;
  logic beat_yumi;
  logic [`C2A_AXI_DATA_W-1:0] beat_data;
  logic pop_word;

  logic [WORD_CNT_W-1:0] word_cnt_r;
  logic [BEAT_CNT_W-1:0] beat_cnt_r;
  logic last_word;
  logic err_r;

  // aw goes out only when the tag has somewhere to go
  assign awvalid_o = offer_v_i & fifo_ready;
  assign fifo_push = offer_v_i & fifo_ready & awready_i;
  assign offer_yumi_o = fifo_push;

  always_comb begin
    aw_o.id = '0;
    aw_o.addr = offer_i.addr;
    aw_o.len = 8'(`C2A_BURST_LEN - 1);
    aw_o.size = 3'($clog2(`C2A_AXI_DATA_W / 8));
    aw_o.burst = c2a_pkg::BURST_INCR;
  end

  c2a_tag_fifo #(
    .els_p(`C2A_TAG_FIFO_ELS),
    .width_p(`C2A_TAG_W)
  ) i_tag_fifo (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .v_i(fifo_push),
    .ready_o(fifo_ready),
    .data_i(offer_i.tag),
    .v_o(fifo_v),
    .data_o(head_tag),
    .yumi_i(fifo_yumi)
  );

  // head tag names the cache whose block is being drained
  assign gather_v = fifo_v & dma_v_i[head_tag];
  assign pop_word = gather_v & gather_ready;
  assign dma_yumi_o = pop_word ? (NUM_CACHE'(1) << head_tag) : '0;

  c2a_word_gather i_gather (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .v_i(gather_v),
    .data_i(dma_data_i[head_tag]),
    .ready_o(gather_ready),
    .v_o(beat_v),
    .data_o(beat_data),
    .yumi_i(beat_yumi)
  );

  // tag retires with the last word of its block
  assign last_word = (word_cnt_r == WORD_CNT_W'(`C2A_BLOCK_WORDS - 1));
  assign fifo_yumi = pop_word & last_word;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      word_cnt_r <= '0;
    end else if (pop_word) begin
      word_cnt_r <= last_word ? '0 : word_cnt_r + 1'b1;
    end
  end

  assign wvalid_o = beat_v;
  assign beat_yumi = beat_v & wready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_r <= '0;
    end else if (beat_yumi) begin
      beat_cnt_r <= w_o.last ? '0 : beat_cnt_r + 1'b1;
    end
  end

  assign w_o.data = beat_data;
  assign w_o.strb = '1;
  assign w_o.last = (beat_cnt_r == BEAT_CNT_W'(`C2A_BURST_LEN - 1));

  // responses always taken, any error is sticky
  assign bready_o = 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_r <= 1'b0;
    end else if (bvalid_i && (b_i.resp == c2a_pkg::RESP_SLVERR ||
                              b_i.resp == c2a_pkg::RESP_DECERR)) begin
      err_r <= 1'b1;
    end
  end

  assign err_o = err_r;

  // a stalled beat keeps its valid and its payload
  a_w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(w_o));

endmodule

// File: hw/c2a_word_gather.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module c2a_word_gather (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       v_i,
  input  logic [`C2A_WORD_W-1:0]     data_i,
  output logic                       ready_o,
  output logic                       v_o,
  output logic [`C2A_AXI_DATA_W-1:0] data_o,
  input  logic                       yumi_i
);

  localparam int SLOTS = `C2A_WORDS_PER_BEAT;
  localparam int CNT_W = $clog2(SLOTS + 1);
  localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

  // slot 0 lands in the low half of the beat
  logic [SLOTS-1:0][`C2A_WORD_W-1:0] slots_r;
  logic [CNT_W-1:0] cnt_r;
  logic [IDX_W-1:0] wr_idx;
  logic full;
  logic take;

  assign full = (cnt_r == CNT_W'(SLOTS));
  assign v_o = full;

  // a word may enter the same cycle the full beat leaves
  assign ready_o = ~full | yumi_i;
  assign take = v_i & ready_o;

  // refill from the bottom once the beat is gone
  assign wr_idx = yumi_i ? '0 : cnt_r[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_r <= '0;
    end else if (yumi_i) begin
      cnt_r <= take ? CNT_W'(1) : '0;
    end else if (take) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      slots_r[wr_idx] <= data_i;
    end
  end

  assign data_o = slots_r;

endmodule

// File: hw/c2a_tag_fifo.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module c2a_tag_fifo #(
  parameter int els_p = `C2A_TAG_FIFO_ELS,
  parameter int width_p = `C2A_TAG_W
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               v_i,
  output logic               ready_o,
  input  logic [width_p-1:0] data_i,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int PTR_W = (els_p > 1) ? $clog2(els_p) : 1;

  logic [width_p-1:0] mem_r [els_p];
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [PTR_W-1:0] wr_ptr_nxt;
  // tells full from empty when the pointers meet
  logic full_r;
  logic ptr_eq;
  logic full;
  logic empty;

  assign ptr_eq = (rd_ptr_r == wr_ptr_r);
  assign full = ptr_eq & full_r;
  assign empty = ptr_eq & ~full_r;

  // explicit wrap so depths that are not a power of two work
  assign rd_ptr_nxt = (rd_ptr_r == PTR_W'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
  assign wr_ptr_nxt = (wr_ptr_r == PTR_W'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (v_i) begin
        wr_ptr_r <= wr_ptr_nxt;
      end
      if (yumi_i) begin
        rd_ptr_r <= rd_ptr_nxt;
      end
      if (v_i && !yumi_i && wr_ptr_nxt == rd_ptr_r) begin
        full_r <= 1'b1;
      end else if (yumi_i && !v_i) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign ready_o = ~full;
  assign v_o = ~empty;
  assign data_o = mem_r[rd_ptr_r];

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) !(v_i && full));
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) !(yumi_i && empty));

endmodule

// File: hw/c2a_req_arbiter.sv
`timescale 1ns/1ps
`include "c2a_defs.svh"

module c2a_req_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic [`C2A_NUM_CACHE-1:0]                   req_v_i,
  input  logic [`C2A_NUM_CACHE-1:0][`C2A_ADDR_W-1:0]  req_addr_i,
  output logic [`C2A_NUM_CACHE-1:0]                   req_yumi_o,
  output c2a_pkg::wb_req_s                            offer_o,
  output logic                                        offer_v_o,
  input  logic                                        offer_yumi_i
);

  localparam int NUM_CACHE = `C2A_NUM_CACHE;
  localparam int TAG_W = `C2A_TAG_W;

  c2a_pkg::arb_state_e state_r;
  logic [TAG_W-1:0] last_r;
  logic [TAG_W-1:0] tag_r;
  logic [`C2A_ADDR_W-1:0] addr_r;
  logic [TAG_W-1:0] cand;
  logic [TAG_W-1:0] pick_tag;
  logic pick_v;

  // first requester after the last winner, wrapping around
  always_comb begin
    pick_v = 1'b0;
    pick_tag = last_r;
    cand = last_r;
    for (int i = 1; i <= NUM_CACHE; i++) begin
      cand = TAG_W'((int'(last_r) + i) % NUM_CACHE);
      if (!pick_v && req_v_i[cand]) begin
        pick_v = 1'b1;
        pick_tag = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= c2a_pkg::ARB_SCAN;
      // so that cache 0 wins first
      last_r <= TAG_W'(NUM_CACHE - 1);
    end else begin
      case (state_r)
        c2a_pkg::ARB_SCAN: begin
          if (pick_v) begin
            state_r <= c2a_pkg::ARB_OFFER;
          end
        end
        default: begin
          if (offer_yumi_i) begin
            state_r <= c2a_pkg::ARB_SCAN;
            last_r <= tag_r;
          end
        end
      endcase
    end
  end

  // winner payload, only loaded while scanning
  always_ff @(posedge clk_i) begin
    if (state_r == c2a_pkg::ARB_SCAN && pick_v) begin
      tag_r <= pick_tag;
      addr_r <= req_addr_i[pick_tag];
    end
  end

  assign offer_v_o = (state_r == c2a_pkg::ARB_OFFER);
  assign offer_o.tag = tag_r;
  assign offer_o.addr = addr_r;

  // winner sees yumi in the cycle its burst address goes out
  assign req_yumi_o = (offer_v_o && offer_yumi_i) ? (NUM_CACHE'(1) << tag_r) : '0;

  a_yumi_needs_offer: assert property (@(posedge clk_i) disable iff (rst_i)
    offer_yumi_i |-> offer_v_o);

endmodule

// File: hw/c2a_pkg.sv
`include "c2a_defs.svh"

package c2a_pkg;

  // axi burst type
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // axi response code
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // arbiter fsm
  typedef enum logic {
    ARB_SCAN,
    ARB_OFFER
  } arb_state_e;

  typedef struct packed {
    logic [`C2A_ID_W-1:0]   id;
    logic [`C2A_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    axi_burst_e             burst;
  } axi_aw_s;

  typedef struct packed {
    logic [`C2A_AXI_DATA_W-1:0]   data;
    logic [`C2A_AXI_DATA_W/8-1:0] strb;
    logic                         last;
  } axi_w_s;

  typedef struct packed {
    logic [`C2A_ID_W-1:0] id;
    axi_resp_e            resp;
  } axi_b_s;

  // write-back request chosen by the arbiter
  typedef struct packed {
    logic [`C2A_TAG_W-1:0]  tag;
    logic [`C2A_ADDR_W-1:0] addr;
  } wb_req_s;

endpackage

// File: hw/c2a_defs.svh
`ifndef C2A_DEFS_SVH
`define C2A_DEFS_SVH

// number of cache dma ports and the width of an index into them
`define C2A_NUM_CACHE 4
`define C2A_TAG_W 2

// cache dma word and axi beat widths
`define C2A_WORD_W 32
`define C2A_AXI_DATA_W 64
`define C2A_WORDS_PER_BEAT 2

// one cache block goes out as one axi burst
`define C2A_BLOCK_WORDS 8
`define C2A_BURST_LEN (`C2A_BLOCK_WORDS / `C2A_WORDS_PER_BEAT)

// axi address and id widths
`define C2A_ADDR_W 32
`define C2A_ID_W 4

// bursts that may be outstanding between aw and the end of their data
`define C2A_TAG_FIFO_ELS 4

`endif
